// File: project.f
+incdir+design
design/tile_mem_pkg.sv
design/mem_req_decode.sv
design/sram_block.sv
design/sram_sp_banked.sv
design/mem_resp_capture.sv
design/tile_mem_top.sv
testbench/tile_mem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the tile memory testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
   --top-module tile_mem_tb -f project.f -o tile_mem_sim

./obj_dir/tile_mem_sim > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
   echo "Simulation failed"
   exit 1
fi

if ! grep -q '\*\* PASS \*\*' sim.log; then
   echo "Simulation ended without a verdict"
   exit 1
fi

echo "Simulation passed"

// File: testbench/tile_mem_tb.sv
`include "tile_mem_params.svh"

module tile_mem_tb
   import tile_mem_pkg::*;
();

   // One table row
   // gap is the number of idle cycles after the row
   typedef struct packed {
      logic        strobe;
      logic        we;
      logic [3:0]  sel;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic        rnd;
      logic [3:0]  gap;
   } stim_t;

   // Expected response and the cycle it must show up in
   typedef struct packed {
      logic [31:0] due;
      mem_resp_t   resp;
   } expect_t;

   logic      clk;
   logic      rst_n;
   logic      host_strobe;
   host_req_t host_req;
   logic      resp_valid;
   mem_resp_t resp;

   // Byte wide reference memory
   logic [7:0]  ref_mem [`TILE_MEM_SIZE];
   stim_t       stim_q [$];
   expect_t     exp_q [$];
   expect_t     head;
   stim_t       cur;
   host_req_t   req_next;
   integer      seed;
   int unsigned cyc;
   int unsigned cycle_limit;

   tile_mem_top uut (
      .clk         (clk),
      .rst_n       (rst_n),
      .host_strobe (host_strobe),
      .host_req    (host_req),
      .resp_valid  (resp_valid),
      .resp        (resp)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic stop_with_error(input string what);
      $display("ERROR: %s", what);
      $display("** FAIL **");
      $fatal(1, "Simulation stopped");
   endtask

   task automatic compare_values(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
      if (got !== exp) begin
         $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
         $display("** FAIL **");
         $fatal(1, "Simulation stopped");
      end
   endtask

   task automatic add_step(input logic strobe, input logic we, input logic [3:0] sel,
                           input logic [31:0] addr, input logic [31:0] wdata,
                           input logic rnd, input int gap);
      stim_t s;
      s = '{strobe: strobe, we: we, sel: sel, addr: addr, wdata: wdata,
            rnd: rnd, gap: 4'(gap)};
      stim_q.push_back(s);
   endtask

   function automatic logic [31:0] model_read(input logic [31:0] addr);
      logic [31:0] w;
      for (int i = 0; i < 4; i++) begin
         w[i*8 +: 8] = ref_mem[int'(addr[12:0]) + i];
      end
      return w;
   endfunction

   // Predict the response and update the model in request order
   task automatic record_expected(input stim_t s);
      expect_t e;
      logic    bad;
      bad = (s.addr[1:0] != 2'b00) || (s.addr >= 32'(`TILE_MEM_SIZE));
      e.due       = cyc + 4;
      e.resp.err  = bad;
      e.resp.we   = s.we;
      e.resp.rdata = (bad || s.we) ? 32'h0 : model_read(s.addr);
      if (!bad && s.we) begin
         for (int i = 0; i < 4; i++) begin
            if (s.sel[i]) begin
               ref_mem[int'(s.addr[12:0]) + i] = s.wdata[i*8 +: 8];
            end
         end
      end
      exp_q.push_back(e);
   endtask

   // Row fields are strobe, we, sel, byte address, write data, random flag and gap
   task automatic load_table();
      // Quiet start
      add_step(0, 0, 4'h0, 32'h0000_0000, 32'h0, 0, 2);
      // Full word write and read back
      add_step(1, 1, 4'hf, 32'h0000_0040, 32'hcafe_f00d, 0, 1);
      add_step(1, 0, 4'h0, 32'h0000_0040, 32'h0, 0, 1);
      // Byte lane merges
      add_step(1, 1, 4'hf, 32'h0000_0080, 32'h1122_3344, 0, 0);
      add_step(1, 1, 4'h5, 32'h0000_0080, 32'haabb_ccdd, 0, 0);
      add_step(1, 0, 4'h0, 32'h0000_0080, 32'h0, 0, 0);
      add_step(1, 1, 4'h8, 32'h0000_0080, 32'h5566_7788, 0, 0);
      add_step(1, 1, 4'h2, 32'h0000_0080, 32'h0, 1, 0);
      add_step(1, 0, 4'h0, 32'h0000_0080, 32'h0, 0, 1);
      // Bank edges written and read back to back
      add_step(1, 1, 4'hf, 32'h0000_07fc, 32'h0, 1, 0);
      add_step(1, 1, 4'hf, 32'h0000_0800, 32'h0, 1, 0);
      add_step(1, 0, 4'h0, 32'h0000_07fc, 32'h0, 0, 0);
      add_step(1, 0, 4'h0, 32'h0000_0800, 32'h0, 0, 0);
      add_step(1, 1, 4'hf, 32'h0000_17fc, 32'h0, 1, 0);
      add_step(1, 1, 4'hf, 32'h0000_1800, 32'h0, 1, 0);
      add_step(1, 1, 4'hf, 32'h0000_1ffc, 32'h0, 1, 0);
      add_step(1, 0, 4'h0, 32'h0000_1800, 32'h0, 0, 0);
      add_step(1, 0, 4'h0, 32'h0000_17fc, 32'h0, 0, 0);
      add_step(1, 0, 4'h0, 32'h0000_1ffc, 32'h0, 0, 1);
      // Rejected requests
      // Address 0x2010 aliases word 0x10
      add_step(1, 1, 4'hf, 32'h0000_0010, 32'h0bad_beef, 0, 0);
      add_step(1, 1, 4'hf, 32'h0000_0012, 32'hffff_ffff, 0, 0);
      add_step(1, 1, 4'hf, 32'h0000_2010, 32'h1234_5678, 0, 0);
      add_step(1, 0, 4'h0, 32'h0000_2010, 32'h0, 0, 0);
      add_step(1, 0, 4'h0, 32'h0000_0011, 32'h0, 0, 0);
      add_step(1, 0, 4'h0, 32'h0000_2000, 32'h0, 0, 0);
      add_step(1, 0, 4'h0, 32'hffff_fff0, 32'h0, 0, 0);
      add_step(1, 0, 4'h0, 32'h0000_0010, 32'h0, 0, 1);
      // Mixed traffic every cycle with read right after write
      add_step(1, 1, 4'hf, 32'h0000_0200, 32'h0, 1, 0);
      add_step(1, 0, 4'h0, 32'h0000_0200, 32'h0, 0, 0);
      add_step(1, 1, 4'hf, 32'h0000_0204, 32'h0, 1, 0);
      add_step(1, 1, 4'h3, 32'h0000_0200, 32'h0, 1, 0);
      add_step(1, 0, 4'h0, 32'h0000_0200, 32'h0, 0, 0);
      add_step(1, 0, 4'h0, 32'h0000_0204, 32'h0, 0, 0);
      add_step(1, 0, 4'h0, 32'h0000_0040, 32'h0, 0, 0);
   endtask

   // Watchdog
   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc >= cycle_limit) begin
         stop_with_error("simulation ran past its cycle limit");
      end
   end

   // Response checker on the falling edge
   always @(negedge clk) begin
      if (rst_n && resp_valid) begin
         if (exp_q.size() == 0) begin
            stop_with_error("response arrived with no request outstanding");
         end else begin
            head = exp_q.pop_front();
            compare_values("resp_cycle", cyc, head.due);
            compare_values("resp.rdata", resp.rdata, head.resp.rdata);
            compare_values("resp.err", 32'(resp.err), 32'(head.resp.err));
            compare_values("resp.we", 32'(resp.we), 32'(head.resp.we));
         end
      end
   end

   initial begin
      seed        = 56442;
      rst_n       = 1'b0;
      host_strobe = 1'b0;
      host_req    = '0;
      load_table();
      // Room for every row plus reset
      cycle_limit = 4 * stim_q.size() + 16;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      foreach (stim_q[n]) begin
         cur = stim_q[n];
         if (cur.rnd) begin
            cur.wdata = $random(seed);
         end
         req_next = '{we: cur.we, sel: cur.sel, addr: cur.addr, wdata: cur.wdata};
         @(posedge clk);
         host_strobe <= cur.strobe;
         host_req    <= req_next;
         if (cur.strobe) begin
            record_expected(cur);
         end
         repeat (cur.gap) begin
            @(posedge clk);
            host_strobe <= 1'b0;
         end
      end
      @(posedge clk);
      host_strobe <= 1'b0;
      // Wait for the queue to drain and for any stray response
      for (int w = 0; w < 8 && exp_q.size() != 0; w++) begin
         @(negedge clk);
      end
      repeat (3) @(negedge clk);
      if (exp_q.size() != 0) begin
         stop_with_error("not every request received a response");
      end else begin
         $display("** PASS **");
         $finish;
      end
   end

endmodule

// File: design/tile_mem_top.sv
`include "tile_mem_params.svh"

module tile_mem_top
   import tile_mem_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      host_strobe,
   input  host_req_t host_req,
   output logic      resp_valid,
   output mem_resp_t resp
);

   // Decoder to memory
   logic                    mem_strobe;
   mem_req_t                mem_req;

   // Decoder to response stage
   logic                    tag_strobe;
   req_tag_t                tag;

   // Memory to response stage
   logic [`TILE_DATA_W-1:0] rdata;

   // Request check and address conversion
   mem_req_decode u_decode (
      .clk         (clk),
      .rst_n       (rst_n),
      .host_strobe (host_strobe),
      .host_req    (host_req),
      .mem_strobe  (mem_strobe),
      .mem_req     (mem_req),
      .tag_strobe  (tag_strobe),
      .tag         (tag)
   );

   // Banked block RAM storage
   sram_sp_banked u_mem (
      .clk        (clk),
      .rst_n      (rst_n),
      .mem_strobe (mem_strobe),
      .mem_req    (mem_req),
      .rdata      (rdata)
   );

   // Response formation
   // Two cycles after the host strobe
   mem_resp_capture u_resp (
      .clk        (clk),
      .rst_n      (rst_n),
      .tag_strobe (tag_strobe),
      .tag        (tag),
      .rdata      (rdata),
      .resp_valid (resp_valid),
      .resp       (resp)
   );

endmodule

// File: design/mem_resp_capture.sv
`include "tile_mem_params.svh"

module mem_resp_capture
   import tile_mem_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    tag_strobe,
   input  req_tag_t                tag,
   input  logic [`TILE_DATA_W-1:0] rdata,
   output logic                    resp_valid,
   output mem_resp_t               resp
);

   // Tag delayed to line up with the RAM output
   logic      tag_strobe_q;
   req_tag_t  tag_q;

   // Response before the output register
   mem_resp_t resp_d;

   // Valid pipeline
   // Two stages, one for the RAM read, one for the response
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tag_strobe_q <= 1'b0;
         resp_valid   <= 1'b0;
      end else begin
         tag_strobe_q <= tag_strobe;
         resp_valid   <= tag_strobe_q;
      end
   end

   // Tag payload follows its strobe
   always_ff @(posedge clk) begin
      if (tag_strobe) begin
         tag_q <= tag;
      end
   end

   // Build response
   // Data only for good reads, zero otherwise
   always_comb begin
      resp_d.err   = tag_q.err;
      resp_d.we    = tag_q.we;
      resp_d.rdata = (tag_q.err || tag_q.we) ? '0 : rdata;
   end

   // Response register
   always_ff @(posedge clk) begin
      if (tag_strobe_q) begin
         resp <= resp_d;
      end
   end

   // Fixed latency of two cycles from tag to response
   a_resp_latency : assert property (
      @(posedge clk) disable iff (!rst_n)
      resp_valid |-> $past(tag_strobe, 2)
   );

endmodule

// File: design/sram_sp_banked.sv
`include "tile_mem_params.svh"

module sram_sp_banked
   import tile_mem_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    mem_strobe,
   input  mem_req_t                mem_req,
   output logic [`TILE_DATA_W-1:0] rdata
);

   // Word address layout
   // Upper bits pick the bank, lower 9 bits the word in that bank
   logic [BANK_SEL_W-1:0]    bank_idx;
   logic [`TILE_BANK_AW-1:0] bank_word;
   logic [3:0]               lane_we;

   // Bank of the last access, used one cycle later
   logic [BANK_SEL_W-1:0]    bank_idx_q;

   // Raw read data of every bank
   logic [`TILE_DATA_W-1:0]  bank_rdata [BANK_NUM];

   assign bank_idx  = BANK_SEL_W'(mem_req.word_addr >> `TILE_BANK_AW);
   assign bank_word = `TILE_BANK_AW'(mem_req.word_addr);

   // Lane enables only for writes
   assign lane_we = mem_req.sel & {4{mem_req.we}};

   // One block RAM per bank
   for (genvar b = 0; b < BANK_NUM; b++) begin : g_bank
      logic bank_en;

      // Only the addressed bank is clocked for this access
      assign bank_en = mem_strobe && (bank_idx == BANK_SEL_W'(b));

      sram_block u_bank (
         .clk   (clk),
         .en    (bank_en),
         .we    (lane_we),
         .addr  (bank_word),
         .wdata (mem_req.wdata),
         .rdata (bank_rdata[b])
      );
   end

   // Remember which bank was accessed
   // Read data shows up a cycle after the address, so the mux
   // must follow the old bank and not the current request
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         bank_idx_q <= '0;
      end else if (mem_strobe) begin
         bank_idx_q <= bank_idx;
      end
   end

   // Output mux
   assign rdata = bank_rdata[bank_idx_q];

   // Range check upstream keeps every access inside an existing bank
   a_bank_in_range : assert property (
      @(posedge clk) disable iff (!rst_n)
      mem_strobe |-> (bank_idx < BANK_NUM)
   );

endmodule

// File: design/sram_block.sv
`include "tile_mem_params.svh"

module sram_block
   import tile_mem_pkg::*;
(
   input  logic                     clk,
   input  logic                     en,
   input  logic [3:0]               we,
   input  logic [`TILE_BANK_AW-1:0] addr,
   input  logic [`TILE_DATA_W-1:0]  wdata,
   output logic [`TILE_DATA_W-1:0]  rdata
);

   // Behavioral block RAM
   // One 16 kbit bank, 512 words of 32 bits
   logic [`TILE_DATA_W-1:0] mem [BANK_WORDS];

   // Byte lane writes
   // Each enabled lane overwrites its own 8 bits
   always_ff @(posedge clk) begin
      if (en) begin
         for (int i = 0; i < 4; i++) begin
            if (we[i]) begin
               mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
            end
         end
      end
   end

   // Registered read port
   // Read first, so a write cycle returns the old word
   // The response stage drops write data anyway
   always_ff @(posedge clk) begin
      if (en) begin
         rdata <= mem[addr];
      end
   end

endmodule

// File: design/mem_req_decode.sv
`include "tile_mem_params.svh"

module mem_req_decode
   import tile_mem_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      host_strobe,
   input  host_req_t host_req,
   output logic      mem_strobe,
   output mem_req_t  mem_req,
   output logic      tag_strobe,
   output req_tag_t  tag
);

   // Byte address split into word index and byte offset
   logic [29:0] word_idx;
   logic        misaligned;
   logic        out_of_range;
   logic        req_err;

   // Word index straight from the upper address bits
   assign word_idx = host_req.addr[31:2];

   // Only full word accesses are supported
   assign misaligned = |host_req.addr[1:0];

   // Anything past the last word is rejected
   // Comparing the full index catches aliases above the memory too
   assign out_of_range = (word_idx >= 30'(MEM_WORDS));

   // Single point where a request is declared bad
   assign req_err = misaligned | out_of_range;

   // Strobes
   // Memory sees only good requests and the tag path sees every one
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mem_strobe <= 1'b0;
         tag_strobe <= 1'b0;
      end else begin
         mem_strobe <= host_strobe & ~req_err;
         tag_strobe <= host_strobe;
      end
   end

   // Request payload
   // Loaded on any host strobe and qualified downstream by the strobes
   always_ff @(posedge clk) begin
      if (host_strobe) begin
         mem_req.we        <= host_req.we;
         mem_req.sel       <= host_req.sel;
         mem_req.word_addr <= MEM_AW'(word_idx);
         mem_req.wdata     <= host_req.wdata;
      end
   end

   // Tag payload
   always_ff @(posedge clk) begin
      if (host_strobe) begin
         tag.err <= req_err;
         tag.we  <= host_req.we;
      end
   end

   // A request reaching memory always has a clean tag issued with it
   a_mem_strobe_clean : assert property (
      @(posedge clk) disable iff (!rst_n)
      mem_strobe |-> (tag_strobe && !tag.err)
   );

endmodule

// File: design/tile_mem_pkg.sv
`include "tile_mem_params.svh"

package tile_mem_pkg;

   // Memory size in words
   localparam int MEM_WORDS = `TILE_MEM_SIZE / 4;

   // Word address width for the whole memory
   localparam int MEM_AW = $clog2(MEM_WORDS);

   // Words held by one block RAM bank
   localparam int BANK_WORDS = 1 << `TILE_BANK_AW;

   // Bank count, rounded up so a partial bank still gets a RAM
   localparam int BANK_NUM = (MEM_WORDS + BANK_WORDS - 1) / BANK_WORDS;

   // Bank index width, one bit minimum for the single-bank case
   localparam int BANK_SEL_W = (BANK_NUM > 1) ? $clog2(BANK_NUM) : 1;

   // Host side request, byte addressed
   typedef struct packed {
      logic                    we;
      logic [3:0]              sel;
      logic [31:0]             addr;
      logic [`TILE_DATA_W-1:0] wdata;
   } host_req_t;

   // Memory side request, word addressed and already range checked
   typedef struct packed {
      logic                    we;
      logic [3:0]              sel;
      logic [MEM_AW-1:0]       word_addr;
      logic [`TILE_DATA_W-1:0] wdata;
   } mem_req_t;

   // Bookkeeping that rides alongside each request
   typedef struct packed {
      logic err;
      logic we;
   } req_tag_t;

   // Response returned to the host
   typedef struct packed {
      logic [`TILE_DATA_W-1:0] rdata;
      logic                    err;
      logic                    we;
   } mem_resp_t;

endpackage

// File: design/tile_mem_params.svh
`ifndef TILE_MEM_PARAMS_SVH
`define TILE_MEM_PARAMS_SVH

// Tile memory size in bytes
// Four banks of 2 kbyte at the default
`define TILE_MEM_SIZE 8192

// Word address bits inside one bank
// 16 kbit block RAM in 32 bit mode holds 512 words
`define TILE_BANK_AW 9

// Width of one memory word in bits
// Four byte lanes
`define TILE_DATA_W 32

`endif
